// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_vio_switch
RTL_TOP    := vio_switch
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing -Wno-fatal -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: run build lint clean

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "TB PASSED" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/axis_pkg.sv
`include "vio_switch_defines.svh"

package axis_pkg;

  // Stream payload fields
  typedef logic [`VIO_DATA_BITS-1:0]   data_t;
  typedef logic [`VIO_DATA_BITS/8-1:0] keep_t;
  typedef logic [`VIO_PID_BITS-1:0]    pid_t;
  typedef logic [`VIO_DEST_BITS-1:0]   dest_t;

  // One beat as seen on a vFIU sink or source, routing travels on the sideband
  typedef struct packed {
    data_t tdata;
    keep_t tkeep;
    logic  tlast;
    pid_t  tid;
  } axis_beat_t;

  // Beat with its destination attached
  // Used by the service ports and inside the switch
  typedef struct packed {
    axis_beat_t beat;
    dest_t      tdest;
  } axis_routed_t;

endpackage

// File: logic/egress_arbiter.sv
`timescale 1ns/1ps
`include "vio_switch_defines.svh"

module egress_arbiter #(
  parameter int N_IN = `VIO_N_PORTS
) (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  route_pkg::port_vec_t   req,
  input  axis_pkg::axis_routed_t beats [N_IN],
  output route_pkg::port_vec_t   grant_ready,
  output axis_pkg::axis_routed_t m_beat,
  output logic                   m_valid,
  input  logic                   m_ready
);
  import axis_pkg::*;
  import route_pkg::*;

  egress_state_t state_q;
  // Input granted most recently, the search starts just above it
  port_idx_t     last_q;
  port_idx_t     owner_q;
  port_idx_t     pick;
  logic          pick_found;
  port_idx_t     sel;
  logic          sel_valid;
  logic          can_load;
  logic          xfer;
  logic          sel_last;
  axis_routed_t  out_q;
  logic          valid_q;

  // Round-robin search over the requests, wrapping past the top input
  always_comb begin : rr_search
    int idx;
    idx = 0;
    pick = last_q;
    pick_found = 1'b0;
    for (int k = 1; k <= N_IN; k++) begin
      idx = (int'(last_q) + k) % N_IN;
      if (!pick_found && req[idx]) begin
        pick = port_idx_t'(idx);
        pick_found = 1'b1;
      end
    end
  end

  // While locked only the owner may move, other requests wait
  assign sel       = (state_q == EGR_LOCKED) ? owner_q : pick;
  assign sel_valid = (state_q == EGR_LOCKED) ? req[owner_q] : pick_found;
  assign sel_last  = beats[sel].beat.tlast;

  // The register takes a new beat while it hands the old one out
  assign can_load = !valid_q || m_ready;
  assign xfer     = sel_valid && can_load;

  always_comb begin
    grant_ready = '0;
    grant_ready[sel] = xfer;
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state_q <= EGR_IDLE;
      last_q  <= port_idx_t'(N_IN - 1);
      owner_q <= '0;
    end else begin
      case (state_q)
        EGR_IDLE: begin
          if (xfer) begin
            last_q  <= sel;
            owner_q <= sel;
            // Single-beat packets never lock
            if (!sel_last) begin
              state_q <= EGR_LOCKED;
            end
          end
        end
        EGR_LOCKED: begin
          if (xfer && sel_last) begin
            state_q <= EGR_IDLE;
          end
        end
        default: state_q <= EGR_IDLE;
      endcase
    end
  end

  // Output register valid
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (xfer) begin
      valid_q <= 1'b1;
    end else if (m_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (xfer) begin
      out_q <= beats[sel];
    end
  end

  assign m_beat  = out_q;
  assign m_valid = valid_q;

endmodule

// File: logic/ingress_decode.sv
`timescale 1ns/1ps
`include "vio_switch_defines.svh"

module ingress_decode (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  axis_pkg::axis_routed_t s_beat,
  input  logic                   s_valid,
  output logic                   s_ready,
  output route_pkg::port_vec_t   req,
  output axis_pkg::axis_routed_t beat_out,
  output logic                   decode_err,
  input  route_pkg::port_vec_t   grant_ready
);
  import axis_pkg::*;
  import route_pkg::*;

  ingress_state_t state_q;
  port_idx_t      dest_q;
  logic           in_range;
  port_idx_t      cur_dest;
  logic           fwd_ok;
  logic           xfer;
  logic           decode_err_q;

  // Only the first beat's tdest is decoded, later beats follow dest_q
  assign in_range = (s_beat.tdest < dest_t'(`VIO_N_PORTS));
  assign cur_dest = (state_q == ING_FWD) ? dest_q : port_idx_t'(s_beat.tdest);
  assign fwd_ok   = (state_q == ING_FWD) || ((state_q == ING_IDLE) && in_range);

  always_comb begin
    req = '0;
    req[cur_dest] = s_valid && fwd_ok;
  end

  // Dropped packets are swallowed at full rate
  always_comb begin
    case (state_q)
      ING_FWD:  s_ready = grant_ready[cur_dest];
      ING_DROP: s_ready = 1'b1;
      default:  s_ready = s_valid && (!in_range || grant_ready[cur_dest]);
    endcase
  end

  assign xfer     = s_valid && s_ready;
  assign beat_out = s_beat;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      state_q      <= ING_IDLE;
      decode_err_q <= 1'b0;
    end else begin
      // One pulse per misrouted packet, on the cycle after its first beat
      decode_err_q <= (state_q == ING_IDLE) && xfer && !in_range;
      case (state_q)
        ING_IDLE: begin
          if (xfer && !s_beat.beat.tlast) begin
            state_q <= in_range ? ING_FWD : ING_DROP;
          end
        end
        ING_FWD, ING_DROP: begin
          if (xfer && s_beat.beat.tlast) begin
            state_q <= ING_IDLE;
          end
        end
        default: state_q <= ING_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if ((state_q == ING_IDLE) && xfer) begin
      dest_q <= cur_dest;
    end
  end

  assign decode_err = decode_err_q;

endmodule

// File: logic/route_pkg.sv
`include "vio_switch_defines.svh"

package route_pkg;

  // Port number, wide enough for every input and output
  typedef logic [$clog2(`VIO_N_PORTS)-1:0] port_idx_t;

  // One bit per port, used for requests, grants and decode errors
  typedef logic [`VIO_N_PORTS-1:0] port_vec_t;

  // vFIU ports take numbers 0 to N_VFIU-1, the service ports follow
  localparam port_idx_t PORT_HOST_TX = port_idx_t'(`VIO_N_VFIU + 0);
  localparam port_idx_t PORT_HOST_RX = port_idx_t'(`VIO_N_VFIU + 1);
  localparam port_idx_t PORT_RDMA_RX = port_idx_t'(`VIO_N_VFIU + 2);
  // Requests and responses share this port
  localparam port_idx_t PORT_RDMA_TX = port_idx_t'(`VIO_N_VFIU + 3);

  // Ingress packet tracker
  typedef enum logic [1:0] {
    ING_IDLE,
    ING_FWD,
    ING_DROP
  } ingress_state_t;

  // Egress lock, held from the first granted beat to tlast
  typedef enum logic {
    EGR_IDLE,
    EGR_LOCKED
  } egress_state_t;

endpackage

// File: logic/vio_switch.sv
`timescale 1ns/1ps
`include "vio_switch_defines.svh"

module vio_switch (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  axis_pkg::axis_beat_t          vfiu_sink [`VIO_N_VFIU],
  input  logic [`VIO_N_VFIU-1:0]        vfiu_sink_valid,
  input  axis_pkg::dest_t               route_in [`VIO_N_VFIU],
  output logic [`VIO_N_VFIU-1:0]        vfiu_sink_ready,
  input  axis_pkg::axis_routed_t        svc_sink [`VIO_N_SVC],
  input  logic [`VIO_N_SVC-1:0]         svc_sink_valid,
  output logic [`VIO_N_SVC-1:0]         svc_sink_ready,
  output axis_pkg::axis_beat_t          vfiu_src [`VIO_N_VFIU],
  output logic [`VIO_N_VFIU-1:0]        vfiu_src_valid,
  output axis_pkg::dest_t               route_out [`VIO_N_VFIU],
  input  logic [`VIO_N_VFIU-1:0]        vfiu_src_ready,
  output axis_pkg::axis_routed_t        svc_src [`VIO_N_SVC],
  output logic [`VIO_N_SVC-1:0]         svc_src_valid,
  input  logic [`VIO_N_SVC-1:0]         svc_src_ready,
  output route_pkg::port_vec_t          decode_err
);
  import axis_pkg::*;
  import route_pkg::*;

  localparam int N_PORTS  = `VIO_N_PORTS;
  // Service ports sit directly above the vFIU range
  localparam int SVC_BASE = int'(PORT_HOST_TX);

  axis_routed_t       in_beat [N_PORTS];
  logic [N_PORTS-1:0] in_valid;
  logic [N_PORTS-1:0] in_ready;
  axis_routed_t       fwd_beat [N_PORTS];
  port_vec_t          ing_req [N_PORTS];
  port_vec_t          ing_grant [N_PORTS];
  port_vec_t          egr_req [N_PORTS];
  port_vec_t          egr_grant [N_PORTS];
  axis_routed_t       out_beat [N_PORTS];
  logic [N_PORTS-1:0] out_valid;
  logic [N_PORTS-1:0] out_ready;

  // vFIU beats pick up their destination from the route sideband
  for (genvar i = 0; i < `VIO_N_VFIU; i++) begin : g_vfiu
    assign in_beat[i]         = '{beat: vfiu_sink[i], tdest: route_in[i]};
    assign in_valid[i]        = vfiu_sink_valid[i];
    assign vfiu_sink_ready[i] = in_ready[i];
    assign vfiu_src[i]        = out_beat[i].beat;
    assign route_out[i]       = out_beat[i].tdest;
    assign vfiu_src_valid[i]  = out_valid[i];
    assign out_ready[i]       = vfiu_src_ready[i];
  end

  for (genvar k = 0; k < `VIO_N_SVC; k++) begin : g_svc
    assign in_beat[SVC_BASE + k]   = svc_sink[k];
    assign in_valid[SVC_BASE + k]  = svc_sink_valid[k];
    assign svc_sink_ready[k]       = in_ready[SVC_BASE + k];
    assign svc_src[k]              = out_beat[SVC_BASE + k];
    assign svc_src_valid[k]        = out_valid[SVC_BASE + k];
    assign out_ready[SVC_BASE + k] = svc_src_ready[k];
  end

  // Requests go out by destination, grants come back by source
  for (genvar i = 0; i < N_PORTS; i++) begin : g_xbar_row
    for (genvar j = 0; j < N_PORTS; j++) begin : g_xbar_col
      assign egr_req[j][i]   = ing_req[i][j];
      assign ing_grant[i][j] = egr_grant[j][i];
    end
  end

  for (genvar i = 0; i < N_PORTS; i++) begin : g_port
    ingress_decode i_ingress (
      .aclk        (aclk),
      .rst_n       (rst_n),
      .s_beat      (in_beat[i]),
      .s_valid     (in_valid[i]),
      .s_ready     (in_ready[i]),
      .req         (ing_req[i]),
      .beat_out    (fwd_beat[i]),
      .decode_err  (decode_err[i]),
      .grant_ready (ing_grant[i])
    );

    egress_arbiter #(
      .N_IN (N_PORTS)
    ) i_egress (
      .aclk        (aclk),
      .rst_n       (rst_n),
      .req         (egr_req[i]),
      .beats       (fwd_beat),
      .grant_ready (egr_grant[i]),
      .m_beat      (out_beat[i]),
      .m_valid     (out_valid[i]),
      .m_ready     (out_ready[i])
    );
  end

endmodule

// File: logic/vio_switch_defines.svh
`ifndef VIO_SWITCH_DEFINES_SVH
`define VIO_SWITCH_DEFINES_SVH

// Stream payload widths
`define VIO_DATA_BITS 64

// Process ID carried in tid
`define VIO_PID_BITS 6

// Routing destination carried in tdest and on the route sideband
`define VIO_DEST_BITS 14

// User-region ports, numbered from zero
`define VIO_N_VFIU 4

// Host TX, host RX, RDMA RX and RDMA TX
`define VIO_N_SVC 4

// Every port is both an input and an output of the switch
`define VIO_N_PORTS (`VIO_N_VFIU + `VIO_N_SVC)

`endif

// File: test/vio_switch_checks.svh
`ifndef VIO_SWITCH_CHECKS_SVH
`define VIO_SWITCH_CHECKS_SVH

task automatic stop_with_failure(string why);
  $display("%s", why);
  $display("TB FAILED");
  $fatal(1, "Stopping at the first failure");
endtask

task automatic check_beat(string sig, axis_beat_t got, axis_beat_t want);
  if (got !== want) begin
    stop_with_failure($sformatf("Error: %s got 0x%h expected 0x%h", sig, got, want));
  end
endtask

task automatic check_dest(string sig, dest_t got, dest_t want);
  if (got !== want) begin
    stop_with_failure($sformatf("Error: %s got 0x%h expected 0x%h", sig, got, want));
  end
endtask

task automatic check_err(string sig, port_vec_t got, port_vec_t want);
  if (got !== want) begin
    stop_with_failure($sformatf("Error: %s got 0x%h expected 0x%h", sig, got, want));
  end
endtask

// Signal names as they appear on the DUT ports
function automatic string src_name(int j, logic dest);
  if (j < N_VFIU) begin
    return dest ? $sformatf("route_out[%0d]", j) : $sformatf("vfiu_src[%0d]", j);
  end
  return $sformatf("svc_src[%0d].%s", j - N_VFIU, dest ? "tdest" : "beat");
endfunction

function automatic axis_routed_t random_beat(dest_t dest, logic last);
  axis_routed_t b;
  b.beat.tdata = {$random(seed), $random(seed)};
  // Only the last beat may carry a partial keep
  b.beat.tkeep = last ? (keep_t'($random(seed)) | keep_t'(1)) : '1;
  b.beat.tlast = last;
  b.beat.tid   = pid_t'($random(seed));
  b.tdest      = dest;
  return b;
endfunction

// Queue one packet on an input and its expected copy on the output
task automatic add_packet(int src, dest_t dest, dest_t later, int len);
  axis_routed_t b;
  for (int n = 0; n < len; n++) begin
    b = random_beat((n == 0) ? dest : later, n == len - 1);
    in_q[src].push_back(b);
    if (dest < dest_t'(N_PORTS)) begin
      exp_q[int'(dest)].push_back(b);
    end
  end
endtask

task automatic apply_reset();
  @(negedge aclk);
  rst_n = 1'b0;
  drv_valid = '0;
  // Beats still queued are discarded along with the switch state
  foreach (in_q[p]) begin
    in_q[p].delete();
    exp_q[p].delete();
  end
  repeat (4) @(negedge aclk);
  rst_n = 1'b1;
  at_start = '1;
  err_next = '0;
endtask

// One clock of traffic, driven on the falling edge
task automatic step_cycle();
  axis_routed_t want;
  @(negedge aclk);
  steps++;
  for (int p = 0; p < N_PORTS; p++) begin
    drv_valid[p] = (in_q[p].size() != 0);
    if (drv_valid[p]) begin
      drv_beat[p] = in_q[p][0];
    end
    drv_ready[p] = bp_mask[p] ? (($random(seed) & 1) != 0) : 1'b1;
  end
  // Let the ready paths settle, the transfer happens at the next rising edge
  #1;
  check_err("decode_err", decode_err, err_next);
  err_next = '0;
  for (int p = 0; p < N_PORTS; p++) begin
    if (drv_valid[p] && sink_ready[p]) begin
      // A misrouted packet is reported once, on its first beat
      if (at_start[p] && (in_q[p][0].tdest >= dest_t'(N_PORTS))) begin
        err_next[p] = 1'b1;
      end
      at_start[p] = in_q[p][0].beat.tlast;
      if (first_in[p] < 0) begin
        first_in[p] = steps;
      end
      void'(in_q[p].pop_front());
    end
  end
  for (int j = 0; j < N_PORTS; j++) begin
    if (src_valid[j] && (first_out[j] < 0)) begin
      first_out[j] = steps;
    end
    if (src_valid[j] && drv_ready[j]) begin
      if (exp_q[j].size() == 0) begin
        stop_with_failure($sformatf("Output %0d delivered a beat nobody sent to it", j));
      end else begin
        want = exp_q[j].pop_front();
        check_beat(src_name(j, 1'b0), src_beat[j].beat, want.beat);
        check_dest(src_name(j, 1'b1), src_beat[j].tdest, want.tdest);
      end
    end
  end
endtask

`endif

// File: test/tb_vio_switch.sv
`timescale 1ns/1ps
`include "vio_switch_defines.svh"

module tb_vio_switch;
  import axis_pkg::*;
  import route_pkg::*;

  localparam int N_VFIU  = `VIO_N_VFIU;
  localparam int N_PORTS = `VIO_N_PORTS;
  // About 200 cycles of traffic in all, ten times that before giving up
  localparam int MAX_CYCLES = 2000;

  logic                  aclk;
  logic                  rst_n;
  axis_beat_t            vfiu_sink [N_VFIU];
  logic [N_VFIU-1:0]     vfiu_sink_valid;
  dest_t                 route_in [N_VFIU];
  logic [N_VFIU-1:0]     vfiu_sink_ready;
  axis_routed_t          svc_sink [`VIO_N_SVC];
  logic [`VIO_N_SVC-1:0] svc_sink_valid;
  logic [`VIO_N_SVC-1:0] svc_sink_ready;
  axis_beat_t            vfiu_src [N_VFIU];
  logic [N_VFIU-1:0]     vfiu_src_valid;
  dest_t                 route_out [N_VFIU];
  logic [N_VFIU-1:0]     vfiu_src_ready;
  axis_routed_t          svc_src [`VIO_N_SVC];
  logic [`VIO_N_SVC-1:0] svc_src_valid;
  logic [`VIO_N_SVC-1:0] svc_src_ready;
  port_vec_t             decode_err;

  // Per-port views indexed by switch port number
  axis_routed_t drv_beat [N_PORTS];
  port_vec_t    drv_valid;
  port_vec_t    drv_ready;
  port_vec_t    sink_ready;
  port_vec_t    src_valid;
  axis_routed_t src_beat [N_PORTS];

  // Reference model state
  axis_routed_t in_q [N_PORTS][$];
  axis_routed_t exp_q [N_PORTS][$];
  port_vec_t    at_start;
  port_vec_t    err_next;
  port_vec_t    bp_mask;
  int           first_in [N_PORTS];
  int           first_out [N_PORTS];
  int           steps;
  int           cycles;
  int           seed;

  `include "vio_switch_checks.svh"

  vio_switch i_dut (.*);

  for (genvar i = 0; i < N_VFIU; i++) begin : g_vfiu
    assign vfiu_sink[i] = drv_beat[i].beat;
    assign route_in[i]  = drv_beat[i].tdest;
    assign src_beat[i]  = '{beat: vfiu_src[i], tdest: route_out[i]};
  end
  for (genvar k = 0; k < `VIO_N_SVC; k++) begin : g_svc
    assign svc_sink[k]          = drv_beat[N_VFIU + k];
    assign src_beat[N_VFIU + k] = svc_src[k];
  end
  assign {svc_sink_valid, vfiu_sink_valid} = drv_valid;
  assign {svc_src_ready, vfiu_src_ready}   = drv_ready;
  assign sink_ready = {svc_sink_ready, vfiu_sink_ready};
  assign src_valid  = {svc_src_valid, vfiu_src_valid};

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_with_failure($sformatf("Timeout after %0d cycles, traffic never drained", cycles));
    end
  end

  function automatic logic traffic_done();
    for (int p = 0; p < N_PORTS; p++) begin
      if ((in_q[p].size() != 0) || (exp_q[p].size() != 0)) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic run_traffic();
    foreach (first_in[p]) begin
      first_in[p]  = -1;
      first_out[p] = -1;
    end
    while (!traffic_done()) begin
      step_cycle();
    end
    // Idle cycles catch stray beats and late error pulses
    repeat (3) step_cycle();
  endtask

  // Input 0 holds output 1 locked and input 2 is mid-drop when reset hits
  task automatic reset_mid_traffic();
    add_packet(0, 14'd1, 14'd1, 4);
    add_packet(2, 14'd9, 14'd9, 3);
    repeat (2) step_cycle();
    apply_reset();
    check_err("sink_ready", sink_ready, '0);
    check_err("src_valid", src_valid, '0);
    check_err("decode_err", decode_err, '0);
  endtask

  task automatic route_each_port();
    int d;
    for (int p = 0; p < N_PORTS; p++) begin
      d = (p + 3) % N_PORTS;
      add_packet(p, dest_t'(d), dest_t'(d), 3);
      run_traffic();
      if (first_out[d] != first_in[p] + 1) begin
        stop_with_failure($sformatf("Output %0d went valid %0d cycles after input %0d, not 1",
                                    d, first_out[d] - first_in[p], p));
      end
    end
  endtask

  // Input 1 wins from reset, then input 5 is next above it when both contend again
  task automatic contend_for_one_output();
    apply_reset();
    add_packet(1, dest_t'(PORT_RDMA_RX), dest_t'(PORT_RDMA_RX), 4);
    add_packet(5, dest_t'(PORT_RDMA_RX), dest_t'(PORT_RDMA_RX), 3);
    add_packet(1, dest_t'(PORT_RDMA_RX), dest_t'(PORT_RDMA_RX), 2);
    run_traffic();
  endtask

  task automatic stall_outputs();
    bp_mask = port_vec_t'(8'h84);
    add_packet(4, 14'd2, 14'd2, 8);
    add_packet(0, 14'd7, 14'd7, 6);
    add_packet(6, 14'd2, 14'd2, 5);
    run_traffic();
    bp_mask = '0;
  endtask

  task automatic drop_misrouted();
    add_packet(6, 14'd8, 14'd8, 3);
    add_packet(6, 14'd3, 14'd3, 3);
    add_packet(2, 14'h3fff, 14'h3fff, 1);
    add_packet(2, 14'd5, 14'd5, 2);
    run_traffic();
  endtask

  task automatic hold_first_dest();
    add_packet(3, 14'd5, 14'd1, 4);
    add_packet(5, 14'd0, 14'd12, 3);
    run_traffic();
  endtask

  initial begin
    seed      = 19;
    cycles    = 0;
    steps     = 0;
    rst_n     = 1'b0;
    drv_valid = '0;
    drv_ready = '0;
    bp_mask   = '0;
    at_start  = '1;
    err_next  = '0;
    foreach (drv_beat[p]) begin
      drv_beat[p] = '0;
    end
    apply_reset();
    reset_mid_traffic();
    route_each_port();
    contend_for_one_output();
    stall_outputs();
    drop_misrouted();
    hold_first_dest();
    $display("TB PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
+incdir+test
logic/axis_pkg.sv
logic/route_pkg.sv
logic/ingress_decode.sv
logic/egress_arbiter.sv
logic/vio_switch.sv
test/tb_vio_switch.sv
